//--- logic/engine_pkg.sv
// Lane count and queue sizing are fixed here; almost_full_level must leave room for in-flight packets
package engine_pkg;

    // --------------------
    // Sizing
    // --------------------
    localparam int lane_count        = 4;
    localparam int fifo_depth        = 16;
    localparam int almost_full_level = 12;

    // --------------------
    // Field operations
    // --------------------
    // Every operation takes one field and the job constant
    typedef enum logic [2:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_mul  = 3'd2,
        op_and  = 3'd3,
        op_or   = 3'd4,
        op_xor  = 3'd5,
        op_max  = 3'd6,
        op_pass = 3'd7
    } alu_opcode_t;

    // Controller FSM
    typedef enum logic [1:0] {
        state_idle  = 2'd0,
        state_run   = 2'd1,
        state_pause = 2'd2,
        state_drain = 2'd3
    } control_state_t;

endpackage

//--- logic/packet_pkg.sv
// Packet layout has no source-route from or hops fields; count is 8 bits, so a job holds 1 to 255 packets
package packet_pkg;

    // --------------------
    // Field widths
    // --------------------
    localparam int field_width    = 16;
    localparam int address_width  = 16;
    localparam int route_width    = 8;
    localparam int subclass_width = 4;
    localparam int count_width    = 8;

    // Response and request packet
    typedef struct packed {
        logic [address_width-1:0]                             address;
        logic [subclass_width-1:0]                            subclass;
        logic [route_width-1:0]                               route;
        logic [engine_pkg::lane_count-1:0][field_width-1:0]   fields;
    } packet_t;

    // Job settings latched at the configuration strobe
    typedef struct packed {
        engine_pkg::alu_opcode_t   opcode;
        logic [field_width-1:0]    constant;
        logic [route_width-1:0]    route;
        logic [count_width-1:0]    count;
    } job_config_t;

endpackage

//--- logic/alu_feed_if.sv
// Job settings stay stable from configuration until job_done; feed_valid is a one-cycle strobe per packet
`timescale 1ns/1ps

interface alu_feed_if;
    import packet_pkg::*;

    // Controller side
    logic        feed_valid;
    packet_t     packet;
    job_config_t job;

    // Packer side
    logic        almost_full;
    logic        job_done;

    modport feed (output feed_valid, output packet, output job,
                  input almost_full, input job_done);

    modport lane (input feed_valid, input packet, input job);

    modport drain (input feed_valid, input packet, input job,
                   output almost_full, output job_done);

endinterface

//--- logic/packet_fifo.sv
// Depth must be a power of two; a push into a full queue is dropped and pop_data is valid the cycle after pop
`timescale 1ns/1ps

module packet_fifo #(
    parameter int depth = engine_pkg::fifo_depth
) (
    input  logic                ap_clk,
    input  logic                areset_generator,
    input  logic                push,
    input  packet_pkg::packet_t push_data,
    input  logic                pop,
    output packet_pkg::packet_t pop_data,
    output logic                empty,
    output logic                almost_full
);
    import engine_pkg::*;
    import packet_pkg::*;

    packet_t                  mem [depth];
    logic [$clog2(depth)-1:0] wr_ptr;
    logic [$clog2(depth)-1:0] rd_ptr;
    logic [$clog2(depth):0]   fill;
    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign empty       = (fill == '0);
    assign full        = (fill == depth);
    assign almost_full = (fill >= almost_full_level);
    assign do_pop      = pop && !empty;
    assign do_push     = push && (!full || do_pop);

    // Storage and read register
    always_ff @(posedge ap_clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
        if (do_pop) begin
            pop_data <= mem[rd_ptr];
        end
    end

    // --------------------
    // Pointers and occupancy
    // --------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            fill   <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   fill <= fill + 1'b1;
                2'b01:   fill <= fill - 1'b1;
                default: fill <= fill;
            endcase
        end
    end

endmodule

//--- logic/alu_lane.sv
// Arithmetic is modulo 2^16 and max is unsigned; result updates only on feed_valid
`timescale 1ns/1ps

module alu_lane #(
    parameter int lane_index = 0
) (
    input  logic                               ap_clk,
    input  logic                               areset_generator,
    alu_feed_if.lane                           lane,
    output logic [packet_pkg::field_width-1:0] result
);
    import engine_pkg::*;
    import packet_pkg::*;

    logic [field_width-1:0] field;
    logic [field_width-1:0] constant;
    logic [field_width-1:0] next_result;

    assign field    = lane.packet.fields[lane_index];
    assign constant = lane.job.constant;

    always_comb begin
        case (lane.job.opcode)
            op_add:  next_result = field + constant;
            op_sub:  next_result = field - constant;
            // Low half of the product
            op_mul:  next_result = field * constant;
            op_and:  next_result = field & constant;
            op_or:   next_result = field | constant;
            op_xor:  next_result = field ^ constant;
            op_max:  next_result = (field > constant) ? field : constant;
            default: next_result = field;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            result <= '0;
        end else if (lane.feed_valid) begin
            result <= next_result;
        end
    end

endmodule

//--- logic/alu_ops_control.sv
// Config is taken only in idle; responses have no back-pressure so at most 16 may wait at once
`timescale 1ns/1ps

module alu_ops_control (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    config_valid,
    input  packet_pkg::job_config_t config_data,
    input  logic                    response_valid,
    input  packet_pkg::packet_t     response_data,
    alu_feed_if.feed                feed
);
    import engine_pkg::*;
    import packet_pkg::*;

    control_state_t           state;
    control_state_t           next_state;
    logic                     queue_empty;
    logic                     pop;
    logic                     last_pop;
    logic [count_width-1:0]   pop_count;

    // --------------------
    // Input queue
    // --------------------
    packet_fifo #(
        .depth(fifo_depth)
    ) u_input_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (response_valid),
        .push_data       (response_data),
        .pop             (pop),
        .pop_data        (feed.packet),
        .empty           (queue_empty),
        .almost_full     ()
    );

    assign pop      = (state == state_run) && !queue_empty;
    assign last_pop = pop && (pop_count == feed.job.count - 1'b1);

    // --------------------
    // Job FSM
    // --------------------
    always_comb begin
        next_state = state;
        case (state)
            state_idle: begin
                if (config_valid) begin
                    next_state = state_run;
                end
            end
            state_run: begin
                // Last pop wins over a pause request
                if (last_pop) begin
                    next_state = state_drain;
                end else if (feed.almost_full) begin
                    next_state = state_pause;
                end
            end
            state_pause: begin
                if (!feed.almost_full) begin
                    next_state = state_run;
                end
            end
            state_drain: begin
                if (feed.job_done) begin
                    next_state = state_idle;
                end
            end
            default: next_state = state_idle;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state           <= state_idle;
            pop_count       <= '0;
            feed.feed_valid <= 1'b0;
            feed.job        <= '0;
        end else begin
            state           <= next_state;
            // Packet leaves the queue register one cycle after the pop
            feed.feed_valid <= pop;
            if (state == state_idle && config_valid) begin
                feed.job  <= config_data;
                pop_count <= '0;
            end else if (pop) begin
                pop_count <= pop_count + 1'b1;
            end
        end
    end

endmodule

//--- logic/request_packer.sv
// request_valid follows a ready-gated pop by one cycle; done assumes a job count of at least 1
`timescale 1ns/1ps

module request_packer (
    input  logic                                                       ap_clk,
    input  logic                                                       areset_generator,
    alu_feed_if.drain                                                  drain,
    input  logic [engine_pkg::lane_count-1:0][packet_pkg::field_width-1:0] lane_results,
    input  logic                                                       request_ready,
    output logic                                                       request_valid,
    output packet_pkg::packet_t                                        request_data,
    output logic                                                       done
);
    import engine_pkg::*;
    import packet_pkg::*;

    logic                        feed_valid_d;
    logic [address_width-1:0]    meta_address;
    logic [subclass_width-1:0]   meta_subclass;
    packet_t                     push_packet;
    logic                        out_empty;
    logic                        pop;
    logic [count_width-1:0]      emitted;
    logic                        last_request;

    // Meta waits one cycle to line up with the lane results
    always_ff @(posedge ap_clk) begin
        if (drain.feed_valid) begin
            meta_address  <= drain.packet.address;
            meta_subclass <= drain.packet.subclass;
        end
    end

    always_comb begin
        push_packet.address  = meta_address;
        push_packet.subclass = meta_subclass;
        push_packet.route    = drain.job.route;
        push_packet.fields   = lane_results;
    end

    // --------------------
    // Output queue
    // --------------------
    packet_fifo #(
        .depth(fifo_depth)
    ) u_output_fifo (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .push            (feed_valid_d),
        .push_data       (push_packet),
        .pop             (pop),
        .pop_data        (request_data),
        .empty           (out_empty),
        .almost_full     (drain.almost_full)
    );

    assign pop          = request_ready && !out_empty;
    assign last_request = request_valid && (emitted == drain.job.count - 1'b1);
    assign drain.job_done = done;

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            feed_valid_d  <= 1'b0;
            request_valid <= 1'b0;
            emitted       <= '0;
            done          <= 1'b0;
        end else begin
            feed_valid_d  <= drain.feed_valid;
            request_valid <= pop;
            done          <= last_request;
            if (last_request) begin
                emitted <= '0;
            end else if (request_valid) begin
                emitted <= emitted + 1'b1;
            end
        end
    end

endmodule

//--- logic/alu_ops_engine.sv
// Strobe inputs without back-pressure; keep outstanding packets at or below the 16-entry queue depth
`timescale 1ns/1ps

module alu_ops_engine (
    input  logic                    ap_clk,
    input  logic                    areset_generator,
    input  logic                    config_valid,
    input  packet_pkg::job_config_t config_data,
    input  logic                    response_valid,
    input  packet_pkg::packet_t     response_data,
    input  logic                    request_ready,
    output logic                    request_valid,
    output packet_pkg::packet_t     request_data,
    output logic                    done
);
    import engine_pkg::*;
    import packet_pkg::*;

    logic [lane_count-1:0][field_width-1:0] lane_results;

    alu_feed_if feed_bus ();

    alu_ops_control u_control (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .config_valid    (config_valid),
        .config_data     (config_data),
        .response_valid  (response_valid),
        .response_data   (response_data),
        .feed            (feed_bus.feed)
    );

    // --------------------
    // One lane per field
    // --------------------
    for (genvar lane_i = 0; lane_i < lane_count; lane_i++) begin : g_lane
        alu_lane #(
            .lane_index(lane_i)
        ) u_lane (
            .ap_clk          (ap_clk),
            .areset_generator(areset_generator),
            .lane            (feed_bus.lane),
            .result          (lane_results[lane_i])
        );
    end

    request_packer u_packer (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .drain           (feed_bus.drain),
        .lane_results    (lane_results),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request_data    (request_data),
        .done            (done)
    );

endmodule

//--- verification/clock_reset_gen.sv
// Free-running 4 ns clock; reset is held high for the first 8 rising edges, then released
`timescale 1ns/1ps

module clock_reset_gen (
    output logic ap_clk,
    output logic areset_generator
);

    initial begin
        ap_clk           = 1'b0;
        areset_generator = 1'b1;
    end

    always #2 ap_clk = ~ap_clk;

    // Release on a rising edge so the DUT sees a clean low
    initial begin
        repeat (8) @(posedge ap_clk);
        areset_generator <= 1'b0;
    end

endmodule

//--- verification/alu_ops_engine_checker.sv
// Bound into alu_ops_engine; failures count up in failures and stop nothing on their own
`timescale 1ns/1ps

module alu_ops_engine_checker (
    input logic ap_clk,
    input logic areset_generator,
    input logic request_ready,
    input logic request_valid,
    input logic done
);

    int unsigned failures = 0;

    // --------------------
    // Reset behavior
    // --------------------
    reset_quiet: assert property (@(posedge ap_clk)
        areset_generator |=> (!request_valid && !done))
        else begin
            failures++;
            $error("request_valid or done high after a reset cycle");
        end

    // --------------------
    // Output handshake
    // --------------------
    // A request needs a ready-gated pop in the cycle before
    valid_after_ready: assert property (@(posedge ap_clk) disable iff (areset_generator)
        request_valid |-> $past(request_ready))
        else begin
            failures++;
            $error("request_valid without request_ready in the cycle before");
        end

    done_one_cycle: assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |=> !done)
        else begin
            failures++;
            $error("done held longer than one cycle");
        end

    done_after_request: assert property (@(posedge ap_clk) disable iff (areset_generator)
        done |-> $past(request_valid))
        else begin
            failures++;
            $error("done without a request in the cycle before");
        end

endmodule

//--- verification/alu_ops_engine_tb.sv
// Eight jobs, one per opcode; responses are throttled so at most 16 packets are outstanding
`timescale 1ns/1ps

module alu_ops_engine_tb;
    import engine_pkg::*;
    import packet_pkg::*;

    localparam logic [31:0] lfsr_seed          = 32'h2e45bc8c;
    localparam int          job_total          = 8;
    localparam int          max_job_packets    = 23;
    localparam int          pre_config_packets = 3;
    localparam int          timeout_cycles     = job_total * max_job_packets * 60 + 2000;

    logic        ap_clk;
    logic        areset_generator;
    logic        config_valid;
    job_config_t config_data;
    logic        response_valid;
    packet_t     response_data;
    logic        request_ready;
    logic        request_valid;
    packet_t     request_data;
    logic        done;

    logic [31:0] lfsr_state;
    packet_t     expected_q[$];
    int          sent_total;
    int          received_total;
    int          jobs_finished;
    int          current_count;
    int          job_received;
    int          stall_left;
    int          cycle_count;
    logic        last_request_seen;

    clock_reset_gen u_clock_reset (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator)
    );

    alu_ops_engine dut (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .config_valid    (config_valid),
        .config_data     (config_data),
        .response_valid  (response_valid),
        .response_data   (response_data),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .request_data    (request_data),
        .done            (done)
    );

    bind alu_ops_engine alu_ops_engine_checker u_checker (
        .ap_clk          (ap_clk),
        .areset_generator(areset_generator),
        .request_ready   (request_ready),
        .request_valid   (request_valid),
        .done            (done)
    );

    // --------------------
    // Helpers
    // --------------------
    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] bits;
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
            bits = {bits[30:0], lfsr_state[0]};
        end
        return bits;
    endfunction

    task automatic check_value(input string name, input logic [95:0] expected,
                               input logic [95:0] actual);
        if (expected !== actual) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            $display("sim failed");
            $fatal(1, "Stopping at the first mismatch");
        end
    endtask

    // Reference model of one field operation
    function automatic logic [field_width-1:0] model_field(input alu_opcode_t op,
        input logic [field_width-1:0] value, input logic [field_width-1:0] constant);
        logic [31:0] wide;
        case (op)
            op_add:  wide = {16'd0, value} + {16'd0, constant};
            op_sub:  wide = {16'd0, value} + 32'h10000 - {16'd0, constant};
            op_mul:  wide = {16'd0, value} * {16'd0, constant};
            op_and:  wide = {16'd0, value & constant};
            op_or:   wide = {16'd0, value | constant};
            op_xor:  wide = {16'd0, value ^ constant};
            op_max:  wide = (value >= constant) ? {16'd0, value} : {16'd0, constant};
            default: wide = {16'd0, value};
        endcase
        return wide[15:0];
    endfunction

    // Step one clock and drive a random ready, with long stalls now and then
    task automatic advance_cycle();
        @(posedge ap_clk);
        if (stall_left > 0) begin
            stall_left--;
            request_ready <= 1'b0;
        end else if (take_bits(5) == 0) begin
            stall_left = 24 + int'(take_bits(4));
            request_ready <= 1'b0;
        end else begin
            request_ready <= (take_bits(2) != 0);
        end
    endtask

    task automatic send_response(input job_config_t job);
        packet_t pkt;
        packet_t exp;
        int      i;
        pkt.address  = 16'(take_bits(16));
        pkt.subclass = 4'(take_bits(4));
        pkt.route    = 8'(take_bits(8));
        for (i = 0; i < lane_count; i++) begin
            pkt.fields[i] = 16'(take_bits(16));
        end
        exp       = pkt;
        exp.route = job.route;
        for (i = 0; i < lane_count; i++) begin
            exp.fields[i] = model_field(job.opcode, pkt.fields[i], job.constant);
        end
        expected_q.push_back(exp);
        sent_total++;
        response_valid <= 1'b1;
        response_data  <= pkt;
    endtask

    // --------------------
    // One job
    // --------------------
    task automatic run_job(input int job_index, input alu_opcode_t op);
        job_config_t cfg;
        job_config_t bogus;
        int          sent;
        logic        bogus_done;
        cfg.opcode     = op;
        cfg.constant   = 16'(take_bits(16));
        cfg.route      = 8'(take_bits(8));
        cfg.count      = 8'(8 + take_bits(4));
        bogus.opcode   = alu_opcode_t'(op ^ 3'd5);
        bogus.constant = 16'(take_bits(16));
        bogus.route    = ~cfg.route;
        bogus.count    = 8'(1 + take_bits(3));
        current_count  = cfg.count;
        // These wait in the input queue until the job starts
        for (sent = 0; sent < pre_config_packets; sent++) begin
            advance_cycle();
            send_response(cfg);
        end
        advance_cycle();
        response_valid <= 1'b0;
        config_valid   <= 1'b1;
        config_data    <= cfg;
        bogus_done = 1'b0;
        while (sent < cfg.count) begin
            advance_cycle();
            if (!bogus_done && sent >= pre_config_packets + 2) begin
                // Job is running, so this strobe must be ignored
                config_valid <= 1'b1;
                config_data  <= bogus;
                bogus_done = 1'b1;
            end else begin
                config_valid <= 1'b0;
            end
            if ((sent_total - received_total) < fifo_depth && take_bits(2) != 0) begin
                send_response(cfg);
                sent++;
            end else begin
                response_valid <= 1'b0;
            end
        end
        while (jobs_finished <= job_index) begin
            advance_cycle();
            response_valid <= 1'b0;
            config_valid   <= 1'b0;
        end
    endtask

    // --------------------
    // Response monitor
    // --------------------
    always @(posedge ap_clk) begin
        packet_t exp;
        if (!areset_generator) begin
            if (dut.u_checker.failures != 0) begin
                $display("A concurrent assertion in the checker failed");
                $display("sim failed");
                $fatal(1, "Stopping on an assertion failure");
            end
            check_value("done strobe", {95'd0, last_request_seen}, {95'd0, done});
            if (done) begin
                jobs_finished <= jobs_finished + 1;
            end
            last_request_seen = 1'b0;
            if (request_valid) begin
                if (expected_q.size() == 0) begin
                    $display("A request came out with no packet waiting for it");
                    $display("sim failed");
                    $fatal(1, "Stopping on an unexpected request");
                end
                exp = expected_q.pop_front();
                check_value($sformatf("job %0d packet %0d", jobs_finished, job_received),
                            96'(exp), 96'(request_data));
                job_received++;
                if (job_received == current_count) begin
                    last_request_seen = 1'b1;
                    job_received = 0;
                end
                received_total <= received_total + 1;
            end
        end
    end

    always @(posedge ap_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout after %0d cycles, the jobs did not finish", cycle_count);
            $display("sim failed");
            $fatal(1, "Run stopped by the cycle limit");
        end
    end

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        lfsr_state        = lfsr_seed;
        sent_total        = 0;
        received_total    = 0;
        jobs_finished     = 0;
        current_count     = 0;
        job_received      = 0;
        stall_left        = 0;
        cycle_count       = 0;
        last_request_seen = 1'b0;
        config_valid      = 1'b0;
        config_data       = '0;
        response_valid    = 1'b0;
        response_data     = '0;
        request_ready     = 1'b0;
        while (areset_generator !== 1'b0) begin
            @(posedge ap_clk);
        end
        // Nothing may come out before a job is configured
        repeat (10) begin
            advance_cycle();
            check_value("idle request_valid", 96'd0, {95'd0, request_valid});
            check_value("idle done", 96'd0, {95'd0, done});
        end
        for (int j = 0; j < job_total; j++) begin
            run_job(j, alu_opcode_t'(j));
        end
        repeat (4) advance_cycle();
        check_value("leftover expected packets", 96'd0, 96'(expected_q.size()));
        check_value("jobs finished", 96'(job_total), 96'(jobs_finished));
        check_value("requests received", 96'(sent_total), 96'(received_total));
        if (dut.u_checker.failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
logic/engine_pkg.sv
logic/packet_pkg.sv
logic/alu_feed_if.sv
logic/packet_fifo.sv
logic/alu_lane.sv
logic/alu_ops_control.sv
logic/request_packer.sv
logic/alu_ops_engine.sv
verification/clock_reset_gen.sv
verification/alu_ops_engine_checker.sv
verification/alu_ops_engine_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator; exit status 1 on any failure

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

if ! verilator --binary --timing --assert -Wno-fatal -f vlog.f \
        --top-module alu_ops_engine_tb -o alu_ops_engine_sim; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/alu_ops_engine_sim +verilator+error+limit+100 > sim.log 2>&1
status=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    echo "Simulation reported a failure"
    exit 1
fi
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi
exit 0
